/* Bender.yml */
package:
  name: if_stage

sources:
  - verilog/if_pkg.sv
  - verilog/pc_ctrl.sv
  - verilog/branch_target_buffer.sv
  - verilog/pattern_history_table.sv
  - verilog/branch_select.sv
  - verilog/fetch_trace.sv
  - verilog/if_stage_top.sv
  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_if_stage.sv

/* list.f */
verilog/if_pkg.sv
verilog/pc_ctrl.sv
verilog/branch_target_buffer.sv
verilog/pattern_history_table.sv
verilog/branch_select.sv
verilog/fetch_trace.sv
verilog/if_stage_top.sv
test/tb_clk_gen.sv
test/tb_if_stage.sv

/* test/tb_clk_gen.sv */
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #5 clk_o = ~clk_o;      // Period 10
        end
    end

    // Two rising edges under reset and release on the falling edge after them
    initial begin
        arst_n_o = 1'b0;
        repeat (2) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* test/tb_if_stage.sv */
`default_nettype none

module tb_if_stage;
    import if_pkg::*;

    // About 75 groups at up to 50 cycles each plus the idle window
    localparam int MAX_CYCLES = 4000;

    logic          clk;
    logic          arst_n;
    logic          inst_req_o;
    word_t         inst_addr_o;
    logic          inst_addr_ok_i;
    logic          inst_data_ok_i;
    group_data_t   inst_rdata_i;
    logic          stop_fetch_i;
    logic          group_valid_o;
    fetch_group_t  group_o;
    logic          flush_i;
    word_t         flush_pc_i;
    logic          flush_take_i;
    word_t         flush_dest_i;
    logic          exc_redirect_i;
    word_t         exc_pc_i;

    // Reference model state
    logic          m_btb_valid [BTB_ENTRIES];
    logic [25:0]   m_btb_tag [BTB_ENTRIES];
    word_t         m_btb_dest [BTB_ENTRIES];
    logic [1:0]    m_pht [PHT_ENTRIES];
    word_t         model_pc;
    logic          model_halted;
    fetch_group_t  exp_group;
    word_t         exp_next;

    word_t         cache_q [$];     // Accepted but not yet returned
    logic          seen_acc;
    logic          seen_ret;
    logic          seen_xfer;
    word_t         acc_addr;
    int            xfer_count;
    int            cycle_count;
    int            err_count;
    integer        seed;

    // Pending redirect for the next cycle
    logic          pend_flush;
    logic          pend_exc;
    word_t         pend_flush_pc;
    logic          pend_flush_take;
    word_t         pend_flush_dest;
    word_t         pend_exc_pc;

    tb_clk_gen u_clk_gen (
        .clk_o    ( clk    ),
        .arst_n_o ( arst_n )
    );

    if_stage_top if_stage_top_i (
        .clk            ( clk            ),
        .arst_n_i       ( arst_n         ),
        .inst_req_o     ( inst_req_o     ),
        .inst_addr_o    ( inst_addr_o    ),
        .inst_addr_ok_i ( inst_addr_ok_i ),
        .inst_data_ok_i ( inst_data_ok_i ),
        .inst_rdata_i   ( inst_rdata_i   ),
        .stop_fetch_i   ( stop_fetch_i   ),
        .group_valid_o  ( group_valid_o  ),
        .group_o        ( group_o        ),
        .flush_i        ( flush_i        ),
        .flush_pc_i     ( flush_pc_i     ),
        .flush_take_i   ( flush_take_i   ),
        .flush_dest_i   ( flush_dest_i   ),
        .exc_redirect_i ( exc_redirect_i ),
        .exc_pc_i       ( exc_pc_i       )
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic fetch_group_t predict_group(input word_t pc, output word_t next_pc);
        fetch_group_t g;
        word_t        base;
        word_t        wa;
        logic         found;
        base      = {pc[31:4], 4'b0000};
        g         = '0;
        g.base_pc = base;
        g.exc     = pc[1:0] != 2'b00;
        next_pc   = base + GROUP_BYTES;
        found     = 1'b0;
        for (int s = 0; s < GROUP_SLOTS; s++) begin
            wa = base + 4 * s;
            g.inst[32*s +: 32] = wa;     // Each word holds its own address
            if (s >= pc[3:2] && !found) begin
                g.enable[s] = 1'b1;
                if (m_btb_valid[wa[5:2]] && m_btb_tag[wa[5:2]] == wa[31:6]
                    && m_pht[wa[7:2]] >= 2'd2) begin
                    found     = 1'b1;
                    g.take[s] = 1'b1;
                    g.dest    = m_btb_dest[wa[5:2]];
                    next_pc   = g.dest;
                end
            end
        end
        return g;
    endfunction

    task automatic train_model(input word_t pc, input logic taken, input word_t dest);
        if (taken) begin
            m_btb_valid[pc[5:2]] = 1'b1;
            m_btb_tag[pc[5:2]]   = pc[31:6];
            m_btb_dest[pc[5:2]]  = dest;
            if (m_pht[pc[7:2]] != 2'd3) m_pht[pc[7:2]] = m_pht[pc[7:2]] + 2'd1;
        end else begin
            if (m_btb_valid[pc[5:2]] && m_btb_tag[pc[5:2]] == pc[31:6]) begin
                m_btb_valid[pc[5:2]] = 1'b0;
            end
            if (m_pht[pc[7:2]] != 2'd0) m_pht[pc[7:2]] = m_pht[pc[7:2]] - 2'd1;
        end
    endtask

    function automatic logic group_matches(input fetch_group_t got, input fetch_group_t exp);
        logic ok;
        ok = got.base_pc == exp.base_pc && got.enable == exp.enable
             && got.take == exp.take && got.inst == exp.inst && got.exc == exp.exc;
        if (exp.take != '0) begin
            ok = ok && got.dest == exp.dest;    // Dest only means something when taken
        end
        return ok;
    endfunction

    task automatic fail_check(input string msg);
        err_count++;
        $display("error @%0t: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // One cycle of stimulus, cache model and bookkeeping
    ////////////////////////////////////////////////////////////////////////////

    task automatic tick();
        logic [31:0] r;
        word_t       a;
        @(negedge clk);
        if (seen_ret) void'(cache_q.pop_front());
        if (seen_acc) cache_q.push_back(acc_addr);
        if (seen_xfer) begin
            xfer_count++;
            if (exp_group.exc) begin
                model_halted = 1'b1;
            end else begin
                model_pc = exp_next;
            end
        end
        flush_i         = pend_flush;
        flush_pc_i      = pend_flush_pc;
        flush_take_i    = pend_flush_take;
        flush_dest_i    = pend_flush_dest;
        exc_redirect_i  = pend_exc;
        exc_pc_i        = pend_exc_pc;
        if (pend_exc) begin                 // Exception wins and nothing is trained
            model_pc     = pend_exc_pc;
            model_halted = 1'b0;
        end else if (pend_flush) begin
            train_model(pend_flush_pc, pend_flush_take, pend_flush_dest);
            model_pc     = pend_flush_dest;
            model_halted = 1'b0;
        end
        pend_flush = 1'b0;
        pend_exc   = 1'b0;
        r = $random(seed);
        inst_addr_ok_i = r[1:0] != 2'b00;
        stop_fetch_i   = r[3:2] == 2'b00;
        if (cache_q.size() > 0 && r[6:5] != 2'b00) begin
            a              = cache_q[0];
            inst_data_ok_i = 1'b1;
            inst_rdata_i   = {a + 32'd12, a + 32'd8, a + 32'd4, a};
        end else begin
            inst_data_ok_i = 1'b0;
            inst_rdata_i   = '0;
        end
        exp_group = predict_group(model_pc, exp_next);
        #1;
        seen_acc  = inst_req_o && inst_addr_ok_i;
        acc_addr  = inst_addr_o;
        seen_ret  = inst_data_ok_i;
        seen_xfer = group_valid_o && !stop_fetch_i;
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: fetch stream stalled, %0d cycles elapsed", cycle_count);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic wait_groups(input int n);
        int target;
        target = xfer_count + n;
        while (xfer_count < target) tick();
    endtask

    task automatic send_flush(input word_t pc, input logic take, input word_t dest);
        pend_flush      = 1'b1;
        pend_flush_pc   = pc;
        pend_flush_take = take;
        pend_flush_dest = dest;
        tick();
    endtask

    task automatic send_exception(input word_t pc);
        pend_exc    = 1'b1;
        pend_exc_pc = pc;
        tick();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_group_match: assert property (@(posedge clk) disable iff (!arst_n)
        (group_valid_o && !stop_fetch_i) |-> group_matches(group_o, exp_group))
        else fail_check($sformatf(
            "group base %h enable %b take %b, expected base %h enable %b take %b",
            $sampled(group_o.base_pc), $sampled(group_o.enable), $sampled(group_o.take),
            $sampled(exp_group.base_pc), $sampled(exp_group.enable), $sampled(exp_group.take)));

    a_halt_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        (group_valid_o && !stop_fetch_i) |-> !model_halted)
        else fail_check($sformatf("group at %h transferred after an address error",
            $sampled(group_o.base_pc)));

    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (inst_req_o && !inst_addr_ok_i) |=> (inst_req_o && $stable(inst_addr_o)))
        else fail_check($sformatf("request at %h dropped or changed before acceptance",
            $sampled(inst_addr_o)));

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        inst_addr_ok_i  = 1'b0;
        inst_data_ok_i  = 1'b0;
        inst_rdata_i    = '0;
        stop_fetch_i    = 1'b0;
        flush_i         = 1'b0;
        flush_pc_i      = '0;
        flush_take_i    = 1'b0;
        flush_dest_i    = '0;
        exc_redirect_i  = 1'b0;
        exc_pc_i        = '0;
        pend_flush      = 1'b0;
        pend_exc        = 1'b0;
        pend_flush_pc   = '0;
        pend_flush_take = 1'b0;
        pend_flush_dest = '0;
        pend_exc_pc     = '0;
        seen_acc        = 1'b0;
        seen_ret        = 1'b0;
        seen_xfer       = 1'b0;
        acc_addr        = '0;
        xfer_count      = 0;
        cycle_count     = 0;
        err_count       = 0;
        seed            = 32'h2187_eb6b;
        model_pc        = RESET_PC;
        model_halted    = 1'b0;
        for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_btb_valid[i] = 1'b0;
            m_btb_tag[i]   = '0;
            m_btb_dest[i]  = '0;
        end
        for (int i = 0; i < PHT_ENTRIES; i++) m_pht[i] = PHT_INIT;
        exp_group = predict_group(model_pc, exp_next);
        @(posedge arst_n);

        wait_groups(20);                                    // Reset stream with stalls
        send_flush(32'h0000_0A40, 1'b0, 32'h0000_1208);     // Resume at slot 2
        wait_groups(8);
        send_flush(32'h0000_1008, 1'b1, 32'h0000_2004);     // Taken branch at slot 2
        wait_groups(6);
        send_exception(32'h0000_1000);                      // Refetch the branch group
        wait_groups(6);

        // Exception and flush together
        pend_flush      = 1'b1;
        pend_flush_pc   = 32'h0000_3004;
        pend_flush_take = 1'b1;
        pend_flush_dest = 32'h0000_4000;
        send_exception(32'h0000_3000);
        wait_groups(6);

        for (int i = 0; i < 4; i++) begin
            r = $random(seed);
            send_flush({16'h0000, r[31:18], 2'b00}, r[0], {16'h0001, r[15:4], r[3:2], 2'b00});
            wait_groups(5);
        end

        send_exception(32'h0000_5006);                      // Misaligned target
        wait_groups(1);
        repeat (40) tick();
        send_exception(32'h0000_6000);
        wait_groups(6);

        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/branch_select.sv */
`default_nettype none

module branch_select (
    input  wire  if_pkg::word_t                         pc_i,
    input  wire  if_pkg::slot_mask_t                    btb_hit_i,
    input  wire  if_pkg::word_t [if_pkg::GROUP_SLOTS-1:0] btb_target_i,
    input  wire  if_pkg::slot_mask_t                    pht_taken_i,
    output if_pkg::pred_t                               pred_o
);
    import if_pkg::*;

    logic [1:0] offset;
    word_t      seq_pc;
    logic       found;

    assign offset = pc_i[3:2];
    assign seq_pc = {pc_i[31:4], 4'b0000} + word_t'(GROUP_BYTES);

    // First slot from the offset on where BTB and PHT agree ends the group
    always_comb begin
        found          = 1'b0;
        pred_o         = '0;
        pred_o.next_pc = seq_pc;
        for (int s = 0; s < GROUP_SLOTS; s++) begin
            if (s >= offset && !found) begin
                pred_o.enable[s] = 1'b1;
                if (btb_hit_i[s] && pht_taken_i[s]) begin
                    found          = 1'b1;
                    pred_o.take[s] = 1'b1;
                    pred_o.dest    = btb_target_i[s];
                    pred_o.next_pc = btb_target_i[s];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/branch_target_buffer.sv */
`default_nettype none

module branch_target_buffer (
    input  wire                                         clk,
    input  wire                                         arst_n_i,
    input  wire  if_pkg::word_t                         pc_i,
    input  wire  if_pkg::train_t                        train_i,
    output if_pkg::slot_mask_t                          hit_o,
    output if_pkg::word_t [if_pkg::GROUP_SLOTS-1:0]     target_o
);
    import if_pkg::*;

    logic [BTB_ENTRIES-1:0] valid_q;
    btb_tag_t               tag_q [BTB_ENTRIES];
    word_t                  dest_q [BTB_ENTRIES];
    btb_idx_t               rd_idx [GROUP_SLOTS];
    btb_idx_t               wr_idx;
    btb_tag_t               wr_tag;
    logic                   wr_match;

    ////////////////////////////////////////////////////////////////////////////
    // Lookup of all four slots of the group
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int s = 0; s < GROUP_SLOTS; s++) begin
            rd_idx[s]   = btb_idx_t'({pc_i[5:4], 2'(s)});
            hit_o[s]    = valid_q[rd_idx[s]] && (tag_q[rd_idx[s]] == pc_i[31:6]);
            target_o[s] = dest_q[rd_idx[s]];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Update from a flush
    ////////////////////////////////////////////////////////////////////////////

    assign wr_idx   = train_i.pc[5:2];
    assign wr_tag   = train_i.pc[31:6];
    assign wr_match = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else if (train_i.valid) begin
            if (train_i.taken) begin
                valid_q[wr_idx] <= 1'b1;
            end else if (wr_match) begin
                valid_q[wr_idx] <= 1'b0;    // Not taken, drop stale target
            end
        end
    end

    always_ff @(posedge clk) begin
        if (train_i.valid && train_i.taken) begin
            tag_q[wr_idx]  <= wr_tag;
            dest_q[wr_idx] <= train_i.dest;
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch_trace.sv */
`default_nettype none

module fetch_trace (
    input  wire                         clk,
    input  wire                         arst_n_i,
    input  wire                         inst_req_i,
    input  wire                         inst_addr_ok_i,
    input  wire                         inst_data_ok_i,
    input  wire  if_pkg::group_data_t   inst_rdata_i,
    input  wire  if_pkg::word_t         pc_i,
    input  wire  if_pkg::pred_t         pred_i,
    input  wire  if_pkg::redirect_t     redirect_i,
    input  wire                         stop_fetch_i,
    output logic                        can_issue_o,
    output logic                        group_valid_o,
    output if_pkg::fetch_group_t        group_o
);
    import if_pkg::*;

    fetch_group_t           ent_q [TRACE_DEPTH];
    logic [TRACE_DEPTH-1:0] busy_q;
    logic [TRACE_DEPTH-1:0] filled_q;
    logic [TRACE_DEPTH-1:0] cancel_q;
    trace_ptr_t             alloc_ptr_q;
    trace_ptr_t             fill_ptr_q;
    trace_ptr_t             head_ptr_q;
    logic                   alloc;
    logic                   head_ready;
    logic                   pop;

    assign alloc      = inst_req_i & inst_addr_ok_i;
    assign head_ready = busy_q[head_ptr_q] & filled_q[head_ptr_q];

    // Killed entries leave without being presented
    assign group_valid_o = head_ready & ~cancel_q[head_ptr_q] & ~redirect_i.valid;
    assign pop           = head_ready & (cancel_q[head_ptr_q] | redirect_i.valid | ~stop_fetch_i);
    assign can_issue_o   = ~(&busy_q) & ~stop_fetch_i;
    assign group_o       = ent_q[head_ptr_q];

    ////////////////////////////////////////////////////////////////////////////
    // Ring control
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q      <= '0;
            filled_q    <= '0;
            cancel_q    <= '0;
            alloc_ptr_q <= '0;
            fill_ptr_q  <= '0;
            head_ptr_q  <= '0;
        end else begin
            if (redirect_i.valid) begin
                cancel_q <= cancel_q | busy_q;
            end
            if (pop) begin
                busy_q[head_ptr_q] <= 1'b0;
                head_ptr_q         <= head_ptr_q + 1'b1;
            end
            if (alloc) begin
                busy_q[alloc_ptr_q]   <= 1'b1;
                filled_q[alloc_ptr_q] <= 1'b0;
                cancel_q[alloc_ptr_q] <= redirect_i.valid;  // Born dead during a redirect
                alloc_ptr_q           <= alloc_ptr_q + 1'b1;
            end
            // Returns come back in request order
            if (inst_data_ok_i) begin
                filled_q[fill_ptr_q] <= 1'b1;
                fill_ptr_q           <= fill_ptr_q + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Entry payload
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (alloc) begin
            ent_q[alloc_ptr_q].base_pc <= {pc_i[31:4], 4'b0000};
            ent_q[alloc_ptr_q].enable  <= pred_i.enable;
            ent_q[alloc_ptr_q].take    <= pred_i.take;
            ent_q[alloc_ptr_q].dest    <= pred_i.dest;
            ent_q[alloc_ptr_q].exc     <= pc_i[1:0] != 2'b00;   // Address error
        end
        if (inst_data_ok_i) begin
            ent_q[fill_ptr_q].inst <= inst_rdata_i;
        end
    end

endmodule

`default_nettype wire

/* verilog/if_pkg.sv */
`default_nettype none

package if_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and table geometry
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [31:0]  word_t;
    typedef logic [127:0] group_data_t;     // Slot 0 in the low word
    typedef logic [3:0]   slot_mask_t;

    localparam int    GROUP_SLOTS = 4;
    localparam int    GROUP_BYTES = 16;
    localparam word_t RESET_PC    = 32'hBFC0_0000;

    localparam int BTB_ENTRIES = 16;        // Indexed by pc[5:2]
    localparam int PHT_ENTRIES = 64;        // Indexed by pc[7:2]
    localparam int TRACE_DEPTH = 2;         // Requests in flight

    typedef logic [25:0]                      btb_tag_t;    // pc[31:6]
    typedef logic [$clog2(BTB_ENTRIES)-1:0]   btb_idx_t;
    typedef logic [$clog2(PHT_ENTRIES)-1:0]   pht_idx_t;
    typedef logic [1:0]                       pht_cnt_t;
    typedef logic [$clog2(TRACE_DEPTH)-1:0]   trace_ptr_t;

    localparam pht_cnt_t PHT_INIT = 2'b01;  // Weakly not taken

    typedef enum logic [1:0] {
        RUN,
        HOLD_REDIRECT,
        HALT
    } pc_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic  valid;
        word_t target;
        logic  train;       // Winner was a flush
    } redirect_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        logic  taken;
        word_t dest;
    } train_t;

    typedef struct packed {
        slot_mask_t take;
        word_t      dest;
        slot_mask_t enable;
        word_t      next_pc;
    } pred_t;

    typedef struct packed {
        word_t       base_pc;
        slot_mask_t  enable;
        slot_mask_t  take;
        word_t       dest;
        group_data_t inst;
        logic        exc;   // Address error
    } fetch_group_t;

endpackage

`default_nettype wire

/* verilog/if_stage_top.sv */
`default_nettype none

module if_stage_top (
    input  wire                         clk,
    input  wire                         arst_n_i,
    // Cache port
    output logic                        inst_req_o,
    output if_pkg::word_t               inst_addr_o,
    input  wire                         inst_addr_ok_i,
    input  wire                         inst_data_ok_i,
    input  wire  if_pkg::group_data_t   inst_rdata_i,
    // Instruction queue
    input  wire                         stop_fetch_i,
    output logic                        group_valid_o,
    output if_pkg::fetch_group_t        group_o,
    // Branch misprediction
    input  wire                         flush_i,
    input  wire  if_pkg::word_t         flush_pc_i,
    input  wire                         flush_take_i,
    input  wire  if_pkg::word_t         flush_dest_i,
    // Exception
    input  wire                         exc_redirect_i,
    input  wire  if_pkg::word_t         exc_pc_i
);
    import if_pkg::*;

    word_t                       pc;
    redirect_t                   redirect;
    train_t                      train;
    pred_t                       pred;
    slot_mask_t                  btb_hit;
    word_t [GROUP_SLOTS-1:0]     btb_target;
    slot_mask_t                  pht_taken;
    logic                        can_issue;

    pc_ctrl u_pc_ctrl (
        .clk            ( clk            ),
        .arst_n_i       ( arst_n_i       ),
        .inst_addr_ok_i ( inst_addr_ok_i ),
        .flush_i        ( flush_i        ),
        .flush_pc_i     ( flush_pc_i     ),
        .flush_take_i   ( flush_take_i   ),
        .flush_dest_i   ( flush_dest_i   ),
        .exc_redirect_i ( exc_redirect_i ),
        .exc_pc_i       ( exc_pc_i       ),
        .pred_i         ( pred           ),
        .can_issue_i    ( can_issue      ),
        .inst_req_o     ( inst_req_o     ),
        .inst_addr_o    ( inst_addr_o    ),
        .pc_o           ( pc             ),
        .redirect_o     ( redirect       ),
        .train_o        ( train          )
    );

    branch_target_buffer u_branch_target_buffer (
        .clk      ( clk        ),
        .arst_n_i ( arst_n_i   ),
        .pc_i     ( pc         ),
        .train_i  ( train      ),
        .hit_o    ( btb_hit    ),
        .target_o ( btb_target )
    );

    pattern_history_table u_pattern_history_table (
        .clk      ( clk       ),
        .arst_n_i ( arst_n_i  ),
        .pc_i     ( pc        ),
        .train_i  ( train     ),
        .taken_o  ( pht_taken )
    );

    branch_select u_branch_select (
        .pc_i         ( pc         ),
        .btb_hit_i    ( btb_hit    ),
        .btb_target_i ( btb_target ),
        .pht_taken_i  ( pht_taken  ),
        .pred_o       ( pred       )
    );

    fetch_trace u_fetch_trace (
        .clk            ( clk            ),
        .arst_n_i       ( arst_n_i       ),
        .inst_req_i     ( inst_req_o     ),
        .inst_addr_ok_i ( inst_addr_ok_i ),
        .inst_data_ok_i ( inst_data_ok_i ),
        .inst_rdata_i   ( inst_rdata_i   ),
        .pc_i           ( pc             ),
        .pred_i         ( pred           ),
        .redirect_i     ( redirect       ),
        .stop_fetch_i   ( stop_fetch_i   ),
        .can_issue_o    ( can_issue      ),
        .group_valid_o  ( group_valid_o  ),
        .group_o        ( group_o        )
    );

endmodule

`default_nettype wire

/* verilog/pattern_history_table.sv */
`default_nettype none

module pattern_history_table (
    input  wire                     clk,
    input  wire                     arst_n_i,
    input  wire  if_pkg::word_t     pc_i,
    input  wire  if_pkg::train_t    train_i,
    output if_pkg::slot_mask_t      taken_o
);
    import if_pkg::*;

    pht_cnt_t cnt_q [PHT_ENTRIES];
    pht_idx_t wr_idx;

    always_comb begin
        for (int s = 0; s < GROUP_SLOTS; s++) begin
            taken_o[s] = cnt_q[pht_idx_t'({pc_i[7:4], 2'(s)})][1];   // MSB set means taken
        end
    end

    assign wr_idx = train_i.pc[7:2];

    // Two-bit saturating update
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                cnt_q[i] <= PHT_INIT;
            end
        end else if (train_i.valid) begin
            if (train_i.taken && cnt_q[wr_idx] != 2'b11) begin
                cnt_q[wr_idx] <= cnt_q[wr_idx] + 2'b01;
            end else if (!train_i.taken && cnt_q[wr_idx] != 2'b00) begin
                cnt_q[wr_idx] <= cnt_q[wr_idx] - 2'b01;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/pc_ctrl.sv */
`default_nettype none

module pc_ctrl (
    input  wire                     clk,
    input  wire                     arst_n_i,
    input  wire                     inst_addr_ok_i,
    input  wire                     flush_i,
    input  wire  if_pkg::word_t     flush_pc_i,
    input  wire                     flush_take_i,
    input  wire  if_pkg::word_t     flush_dest_i,
    input  wire                     exc_redirect_i,
    input  wire  if_pkg::word_t     exc_pc_i,
    input  wire  if_pkg::pred_t     pred_i,
    input  wire                     can_issue_i,
    output logic                    inst_req_o,
    output if_pkg::word_t           inst_addr_o,
    output if_pkg::word_t           pc_o,
    output if_pkg::redirect_t       redirect_o,
    output if_pkg::train_t          train_o
);
    import if_pkg::*;

    pc_state_t state_q;
    word_t     pc_q;
    word_t     hold_target_q;
    word_t     redir_target;
    logic      req_hold_q;
    logic      redir_pulse;
    logic      flush_wins;
    logic      new_req;
    logic      accept;
    logic      pending;
    logic      misaligned;

    assign redir_pulse  = exc_redirect_i | flush_i;
    assign flush_wins   = flush_i & ~exc_redirect_i;       // Exception has priority
    assign redir_target = exc_redirect_i ? exc_pc_i : flush_dest_i;
    assign misaligned   = pc_q[1:0] != 2'b00;

    ////////////////////////////////////////////////////////////////////////////
    // Cache request
    ////////////////////////////////////////////////////////////////////////////

    // Held request keeps address stable until accepted
    assign new_req     = (state_q == RUN) & can_issue_i & ~redir_pulse;
    assign inst_req_o  = req_hold_q | new_req;
    assign accept      = inst_req_o & inst_addr_ok_i;
    assign pending     = req_hold_q & ~inst_addr_ok_i;
    assign inst_addr_o = {pc_q[31:4], 4'b0000};
    assign pc_o        = pc_q;

    always_comb begin
        redirect_o.valid  = redir_pulse | (state_q == HOLD_REDIRECT);
        redirect_o.target = redir_pulse ? redir_target : hold_target_q;
        redirect_o.train  = flush_wins;
    end

    always_comb begin
        train_o.valid = redirect_o.train;
        train_o.pc    = flush_pc_i;
        train_o.taken = flush_take_i;
        train_o.dest  = flush_dest_i;
    end

    always_ff @(posedge clk) begin
        if (redir_pulse) begin
            hold_target_q <= redir_target;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= RUN;
            pc_q       <= RESET_PC;
            req_hold_q <= 1'b0;
        end else begin
            req_hold_q <= inst_req_o & ~inst_addr_ok_i;
            case (state_q)
                RUN: begin
                    if (redir_pulse) begin
                        if (pending) begin
                            state_q <= HOLD_REDIRECT;   // Let the old request drain
                        end else begin
                            pc_q <= redirect_o.target;
                        end
                    end else if (accept) begin
                        if (misaligned) begin
                            state_q <= HALT;
                        end else begin
                            pc_q <= pred_i.next_pc;
                        end
                    end
                end
                HOLD_REDIRECT: begin
                    if (accept) begin
                        state_q <= RUN;
                        pc_q    <= redirect_o.target;
                    end
                end
                HALT: begin
                    if (redir_pulse) begin
                        state_q <= RUN;
                        pc_q    <= redirect_o.target;
                    end
                end
                default: begin
                    state_q <= RUN;
                end
            endcase
        end
    end

endmodule

`default_nettype wire
